/* inst_rom.hex */
// one 32-bit instruction word per line, word 0 sits at the reset vector
02800c0c
02801c0d
0010358e
1400002f
29800184
28800185
02bffc84
5c001085
0015000c
03400000
02800404
64000c85
4c000020
1c00000f
0380080e
50000400

/* filelist.f */
+incdir+.
fetch_pkg.sv
pc_gen.sv
inst_rom.sv
fetch_queue.sv
fetch_ctrl.sv
fetch_top.sv
tb_fetch_top.sv

/* run.sh */
#!/bin/sh
# build the fetch front end testbench with verilator, run it, check the log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_fetch_top -f filelist.f \
    && ./obj_dir/Vtb_fetch_top | tee sim.log \
    && grep -q "^Simulation completed successfully$" sim.log \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }

/* tb_fetch_top.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module tb_fetch_top;

    localparam int num_cycles   = 3000;
    localparam int reset_cycles = 3;
    localparam int clk_period   = 40;

    logic        clk = 1'b0;
    logic        rst;
    logic        ex_flush;
    logic [31:0] ex_entry;
    logic        ertn_flush;
    logic [31:0] ertn_entry;
    logic        br_taken;
    logic [31:0] br_target;
    logic        credit_return;
    logic        out_valid;
    logic [31:0] out_pc;
    logic [31:0] out_inst;
    logic        out_has_exception;
    logic [5:0]  out_ecode;
    logic [8:0]  out_esubcode;

    // reference model state.
    logic [31:0] rom_model [`FETCH_ROM_WORDS];
    logic [31:0] rng;
    logic [31:0] exp_pc;
    logic        adef_seen;    // fetch is stalled after an exception entry.
    string       stream_label;
    int          model_credits;
    int          deliveries;
    int          returns;
    int          starve_left;
    int          value_errors;
    int          protocol_errors;

    fetch_top fetch_top_i (
        .clk               (clk),
        .rst               (rst),
        .ex_flush          (ex_flush),
        .ex_entry          (ex_entry),
        .ertn_flush        (ertn_flush),
        .ertn_entry        (ertn_entry),
        .br_taken          (br_taken),
        .br_target         (br_target),
        .credit_return     (credit_return),
        .out_valid         (out_valid),
        .out_pc            (out_pc),
        .out_inst          (out_inst),
        .out_has_exception (out_has_exception),
        .out_ecode         (out_ecode),
        .out_esubcode      (out_esubcode)
    );

    always #20 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // mostly aligned words in the program image and now and then a misaligned one.
    function automatic logic [31:0] pick_target(input logic [31:0] r);
        logic [31:0] target;
        target = `FETCH_RESET_PC + {26'd0, r[7:4], 2'b00};
        if (r[3:0] < 4'd2) begin
            target = target + {30'd0, (r[9:8] == 2'b00) ? 2'b01 : r[9:8]};
        end
        return target;
    endfunction

    task automatic report_failure(input string what);
        $display("protocol error in %s test: %s", stream_label, what);
        protocol_errors++;
    endtask

    task automatic compare_field(input string field, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s test, %s: expected %h, actual %h",
                     stream_label, field, expected, actual);
            value_errors++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic drive_inputs();
        logic [31:0] r;
        logic [2:0]  srcs;
        logic        redirect_now;
        rng = xorshift32(rng);
        r   = rng;
        if (starve_left > 0) begin
            starve_left--;
        end else if (r[31:24] < 8'd3) begin
            starve_left = 20 + int'(r[23:18]);    // long stretch with no credits back.
        end
        redirect_now = (starve_left == 0) && (r[4:0] == 5'd0);
        srcs = r[7:5];
        if (srcs == 3'b000) begin
            srcs = 3'b001;
        end
        ex_flush   = redirect_now && srcs[2];
        ertn_flush = redirect_now && srcs[1];
        br_taken   = redirect_now && srcs[0];
        credit_return = (starve_left == 0) && (model_credits < `FETCH_DECODE_CREDITS)
                        && (r[9:8] != 2'b00);
        rng = xorshift32(rng);
        ex_entry = pick_target(rng);
        rng = xorshift32(rng);
        ertn_entry = pick_target(rng);
        rng = xorshift32(rng);
        br_target = pick_target(rng);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // model and checks
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic check_outputs();
        logic redirect;
        redirect = ex_flush || ertn_flush || br_taken;
        if (out_valid) begin
            assert (!redirect) else report_failure("out_valid high with a redirect input");
            assert (model_credits > 0) else report_failure("entry sent without a credit");
            assert (deliveries < `FETCH_DECODE_CREDITS + returns)
                else report_failure("more entries delivered than credits granted");
            assert (!adef_seen) else report_failure("entry delivered after an ADEF entry");
            compare_field("pc", exp_pc, out_pc);
            if (exp_pc[1:0] != 2'b00) begin
                stream_label = "adef";
                compare_field("inst", 32'd0, out_inst);
                compare_field("has_exception", 32'd1, {31'd0, out_has_exception});
                compare_field("ecode", 32'd8, {26'd0, out_ecode});
                compare_field("esubcode", 32'd0, {23'd0, out_esubcode});
                adef_seen = 1'b1;
            end else begin
                compare_field("inst", rom_model[exp_pc[9:2]], out_inst);
                compare_field("has_exception", 32'd0, {31'd0, out_has_exception});
                compare_field("ecode", 32'd0, {26'd0, out_ecode});
                compare_field("esubcode", 32'd0, {23'd0, out_esubcode});
            end
            exp_pc = exp_pc + 32'd4;
            deliveries++;
            model_credits--;
            stream_label = "sequential";
        end
        if (credit_return) begin
            model_credits++;
            returns++;
        end
        if (redirect) begin    // the winner by priority becomes the next pc.
            exp_pc = ex_flush ? ex_entry : (ertn_flush ? ertn_entry : br_target);
            adef_seen    = 1'b0;
            stream_label = "redirect";
        end
    endtask

    // outputs are stable by the falling edge.
    always @(negedge clk) begin
        if (rst) begin
            assert (!out_valid) else report_failure("out_valid high during reset");
        end else begin
            check_outputs();
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        rst           = 1'b1;
        ex_flush      = 1'b0;
        ex_entry      = 32'd0;
        ertn_flush    = 1'b0;
        ertn_entry    = 32'd0;
        br_taken      = 1'b0;
        br_target     = 32'd0;
        credit_return = 1'b0;
        rng             = 32'd13;
        exp_pc          = `FETCH_RESET_PC;
        adef_seen       = 1'b0;
        stream_label    = "reset";
        model_credits   = `FETCH_DECODE_CREDITS;
        deliveries      = 0;
        returns         = 0;
        starve_left     = 0;
        value_errors    = 0;
        protocol_errors = 0;
        $readmemh("inst_rom.hex", rom_model);
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (num_cycles) begin
            @(posedge clk);
            #2;
            drive_inputs();
        end
        @(posedge clk);
        #2;
        ex_flush      = 1'b0;
        ertn_flush    = 1'b0;
        br_taken      = 1'b0;
        credit_return = 1'b0;
        repeat (4) @(posedge clk);
        assert (deliveries > num_cycles / 10) else report_failure("too few entries delivered");
        $display("errors: %0d value, %0d protocol, %0d entries, %0d credits returned",
                 value_errors, protocol_errors, deliveries, returns);
        if (value_errors + protocol_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog sized from the stimulus length.
    initial begin
        #((num_cycles + reset_cycles + 50) * clk_period);
        $display("watchdog: the run did not finish in the expected time");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* fetch_top.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_top import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        ex_flush,
    input  logic [31:0] ex_entry,
    input  logic        ertn_flush,
    input  logic [31:0] ertn_entry,
    input  logic        br_taken,
    input  logic [31:0] br_target,
    input  logic        credit_return,
    output logic        out_valid,
    output logic [31:0] out_pc,
    output logic [31:0] out_inst,
    output logic        out_has_exception,
    output logic [5:0]  out_ecode,
    output logic [8:0]  out_esubcode
);

    logic                       fetch_en;
    logic                       rom_en;
    logic [31:0]                fetch_pc;
    logic                       fetch_adef;
    redirect_src_t              redirect_hit;
    logic [31:0]                rom_data;
    logic                       push;
    fetch_entry_t               push_entry;
    logic                       pop;
    logic                       flush;
    fetch_entry_t               head_entry;
    logic                       empty;
    logic [`FETCH_CREDIT_W-1:0] free_slots;

    pc_gen pc_gen_i (
        .clk          (clk),
        .rst          (rst),
        .fetch_en     (fetch_en),
        .ex_flush     (ex_flush),
        .ertn_flush   (ertn_flush),
        .br_taken     (br_taken),
        .ex_entry     (ex_entry),
        .ertn_entry   (ertn_entry),
        .br_target    (br_target),
        .fetch_pc     (fetch_pc),
        .fetch_adef   (fetch_adef),
        .redirect_hit (redirect_hit)
    );

    inst_rom inst_rom_i (
        .clk      (clk),
        .rom_en   (rom_en),
        .rom_addr (fetch_pc[9:2]),    // word index.
        .rom_data (rom_data)
    );

    fetch_queue fetch_queue_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .push       (push),
        .push_entry (push_entry),
        .pop        (pop),
        .head_entry (head_entry),
        .empty      (empty),
        .free_slots (free_slots)
    );

    fetch_ctrl fetch_ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .fetch_pc      (fetch_pc),
        .fetch_adef    (fetch_adef),
        .redirect_hit  (redirect_hit),
        .rom_data      (rom_data),
        .free_slots    (free_slots),
        .empty         (empty),
        .credit_return (credit_return),
        .fetch_en      (fetch_en),
        .rom_en        (rom_en),
        .push          (push),
        .push_entry    (push_entry),
        .pop           (pop),
        .flush         (flush),
        .out_valid     (out_valid)
    );

    // head of the queue goes straight to decode.
    assign out_pc            = head_entry.pc;
    assign out_inst          = head_entry.inst;
    assign out_has_exception = head_entry.has_exception;
    assign out_ecode         = head_entry.ecode;
    assign out_esubcode      = head_entry.esubcode;

endmodule

/* fetch_ctrl.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_ctrl import fetch_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [31:0]                fetch_pc,
    input  logic                       fetch_adef,
    input  redirect_src_t              redirect_hit,
    input  logic [31:0]                rom_data,
    input  logic [`FETCH_CREDIT_W-1:0] free_slots,
    input  logic                       empty,
    input  logic                       credit_return,
    output logic                       fetch_en,
    output logic                       rom_en,
    output logic                       push,
    output fetch_entry_t               push_entry,
    output logic                       pop,
    output logic                       flush,
    output logic                       out_valid
);

    localparam logic [`FETCH_CREDIT_W-1:0] credit_init = `FETCH_DECODE_CREDITS;

    logic                       redirect;
    logic                       fetch_on;        // low in the first cycle after reset.
    logic                       issue;
    logic                       inflight_valid;
    logic                       inflight_adef;
    logic [31:0]                inflight_pc;
    logic [`FETCH_CREDIT_W-1:0] inflight_cnt;
    logic                       adef_stall;
    logic [`FETCH_CREDIT_W-1:0] credits;

    assign redirect = (redirect_hit != redir_none);
    assign flush    = redirect;

    // ~~~~~~~~~~~~~~~~~~~~
    // fetch issue
    // ~~~~~~~~~~~~~~~~~~~~

    // room must remain for the read already in flight.
    assign inflight_cnt = {{(`FETCH_CREDIT_W-1){1'b0}}, inflight_valid};
    assign issue        = fetch_on && !redirect && !adef_stall && (free_slots > inflight_cnt);

    assign fetch_en = issue && !fetch_adef;    // a bad pc stays put.
    assign rom_en   = issue && !fetch_adef;

    always_ff @(posedge clk) begin
        fetch_on <= !rst;
        if (rst || redirect) begin
            inflight_valid <= 1'b0;
            adef_stall     <= 1'b0;
        end else begin
            inflight_valid <= issue;
            if (issue && fetch_adef) begin
                adef_stall <= 1'b1;
            end
        end
        if (issue) begin
            inflight_pc   <= fetch_pc;
            inflight_adef <= fetch_adef;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // entry build
    // ~~~~~~~~~~~~~~~~~~~~

    assign push = inflight_valid && !redirect;    // stale reads are dropped.

    always_comb begin
        push_entry.pc            = inflight_pc;
        push_entry.inst          = inflight_adef ? 32'd0 : rom_data;
        push_entry.has_exception = inflight_adef;
        push_entry.ecode         = inflight_adef ? `FETCH_ECODE_ADEF : 6'd0;
        push_entry.esubcode      = inflight_adef ? `FETCH_ESUBCODE_ADEF : 9'd0;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // decode credits
    // ~~~~~~~~~~~~~~~~~~~~

    assign out_valid = (credits != '0) && !empty && !redirect;
    assign pop       = out_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= credit_init;
        end else begin
            case ({out_valid, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;    // spent and returned together.
            endcase
        end
    end

endmodule

/* fetch_queue.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_queue import fetch_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       push,
    input  fetch_entry_t               push_entry,
    input  logic                       pop,
    output fetch_entry_t               head_entry,
    output logic                       empty,
    output logic [`FETCH_CREDIT_W-1:0] free_slots
);

    localparam int depth = `FETCH_QUEUE_DEPTH;
    localparam int ptr_w = $clog2(depth);
    localparam logic [`FETCH_CREDIT_W-1:0] depth_c = `FETCH_QUEUE_DEPTH;
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);

    fetch_entry_t slots [depth];

    logic [ptr_w-1:0]           head;
    logic [ptr_w-1:0]           tail;
    logic [`FETCH_CREDIT_W-1:0] count;
    logic                       full;
    logic                       do_push;
    logic                       do_pop;

    assign empty      = (count == '0);
    assign full       = (count == depth_c);
    assign free_slots = depth_c - count;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // ~~~~~~~~~~~~~~~~~~~~
    // pointers and count
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst || flush) begin    // flush wins over a push.
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                tail <= (tail == last_ptr) ? '0 : tail + 1'b1;
            end
            if (do_pop) begin
                head <= (head == last_ptr) ? '0 : head + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (do_push && !flush) begin
            slots[tail] <= push_entry;
        end
    end

    assign head_entry = slots[head];

endmodule

/* inst_rom.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module inst_rom (
    input  logic        clk,
    input  logic        rom_en,
    input  logic [7:0]  rom_addr,
    output logic [31:0] rom_data
);

    // ~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~

    logic [31:0] mem [`FETCH_ROM_WORDS];

    // program image.
    initial begin
        $readmemh("inst_rom.hex", mem);
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // read port
    // ~~~~~~~~~~~~~~~~~~~~

    // one cycle of latency, output holds between reads.
    always_ff @(posedge clk) begin
        if (rom_en) begin
            rom_data <= mem[rom_addr];
        end
    end

endmodule

/* pc_gen.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module pc_gen import fetch_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          fetch_en,
    input  logic          ex_flush,
    input  logic          ertn_flush,
    input  logic          br_taken,
    input  logic [31:0]   ex_entry,
    input  logic [31:0]   ertn_entry,
    input  logic [31:0]   br_target,
    output logic [31:0]   fetch_pc,
    output logic          fetch_adef,
    output redirect_src_t redirect_hit
);

    logic [31:0] pc;
    logic [31:0] redirect_pc;
    logic [31:0] seq_pc;

    // exception entry beats ertn, ertn beats branch.
    always_comb begin
        redirect_hit = redir_none;
        redirect_pc  = br_target;
        if (ex_flush) begin
            redirect_hit = redir_exception;
            redirect_pc  = ex_entry;
        end else if (ertn_flush) begin
            redirect_hit = redir_ertn;
            redirect_pc  = ertn_entry;
        end else if (br_taken) begin
            redirect_hit = redir_branch;
        end
    end

    assign seq_pc = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `FETCH_RESET_PC;
        end else if (redirect_hit != redir_none) begin
            pc <= redirect_pc;
        end else if (fetch_en) begin
            pc <= seq_pc;
        end
    end

    assign fetch_pc   = pc;
    assign fetch_adef = (pc[1:0] != 2'b00);    // instructions are word aligned.

endmodule

/* fetch_pkg.sv */
package fetch_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // fetch entry
    // ~~~~~~~~~~~~~~~~~~~~

    // one fetched instruction as handed to decode.
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;             // zero on a fetch exception.
        logic        has_exception;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
    } fetch_entry_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // redirect source
    // ~~~~~~~~~~~~~~~~~~~~

    // which redirect won this cycle, in priority order.
    typedef enum logic [1:0] {
        redir_none      = 2'd0,
        redir_exception = 2'd1,
        redir_ertn      = 2'd2,
        redir_branch    = 2'd3
    } redirect_src_t;

endpackage

/* fetch_settings.svh */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// fetch front end
// ~~~~~~~~~~~~~~~~~~~~

// reset vector of the core.
`define FETCH_RESET_PC 32'h1c00_0000

// instruction rom, word addressed by pc[9:2].
`define FETCH_ROM_WORDS 256

// fetch queue entries.
`define FETCH_QUEUE_DEPTH 4

`define FETCH_DECODE_CREDITS 3    // granted by decode at reset.

// width of the credit and occupancy counters.
`define FETCH_CREDIT_W 3

// ~~~~~~~~~~~~~~~~~~~~
// exception codes
// ~~~~~~~~~~~~~~~~~~~~

// address error on instruction fetch.
`define FETCH_ECODE_ADEF 6'h08
`define FETCH_ESUBCODE_ADEF 9'h000

`endif
